// File: design/apb_consts.svh
/* Bus and memory sizes. Data width must be a multiple of 8 and
   the memory address bits must stay below the bus address width. */

`ifndef APB_CONSTS_SVH
`define APB_CONSTS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Byte address width on APB and on the host port
`define APB_ADDR_WIDTH 16

// Data width, one strobe bit per byte
`define APB_DATA_WIDTH 32

// Implemented byte address bits, 256 bytes
`define APB_MEM_ADDR_BITS 8

`endif

// File: design/apb_pkg.sv
/* Types shared by the APB controller and its testbench.
   State encoding is fixed at 2 bits and the opcode at 1 bit. */

`default_nettype none

package apb_pkg;

  ////////////////////////////////////////
  // Controller FSM states
  ////////////////////////////////////////

  // IDLE waits for req, DONE holds ack until req drops
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2,
    DONE   = 2'd3
  } ctrl_state_e;

  // Host command opcodes
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } apb_op_e;

endpackage

`default_nettype wire

// File: design/apb_if.sv
/* APB bus without PPROT. Single slave, no decoder. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

interface apb_if;

  // Request side, driven by the master
  logic [`APB_ADDR_WIDTH-1:0]   paddr;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [`APB_DATA_WIDTH-1:0]   pwdata;
  logic [`APB_DATA_WIDTH/8-1:0] pstrb;

  // Response side, driven by the slave
  logic                         pready;
  logic [`APB_DATA_WIDTH-1:0]   prdata;
  logic                         pslverr;

  ////////////////////////////////////////
  // Modports
  ////////////////////////////////////////

  modport master (
    output paddr, psel, penable, pwrite, pwdata, pstrb,
    input  pready, prdata, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata, pstrb,
    output pready, prdata, pslverr
  );

endinterface

`default_nettype wire

// File: design/mem_bank.sv
/* No reset, contents undefined until written.
   Read is combinational and returns zero while cs is low. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module mem_bank #(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_SIZE  = 2
) (
  input  logic                         pclk,
  input  logic                         cs,
  input  logic [ADDR_WIDTH-1:0]        addr,
  input  logic [`APB_DATA_WIDTH-1:0]   wdata,
  input  logic [`APB_DATA_WIDTH/8-1:0] wstrb,
  output logic [`APB_DATA_WIDTH-1:0]   rdata
);

  // Byte lanes per word
  localparam int BYTES = `APB_DATA_WIDTH / 8;
  // Word count after dropping the byte offset
  localparam int DEPTH = 2 ** (ADDR_WIDTH - DATA_SIZE);

  logic [`APB_DATA_WIDTH-1:0]     mem [DEPTH];
  logic [ADDR_WIDTH-DATA_SIZE-1:0] word_idx;

  // Byte offset bits ignored
  assign word_idx = addr[ADDR_WIDTH-1:DATA_SIZE];

  ////////////////////////////////////////
  // Byte-lane write
  ////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (cs) begin
      // Only strobed lanes change
      for (int i = 0; i < BYTES; i++) begin
        if (wstrb[i]) begin
          mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // Zero when not selected, so errored reads give zero
  assign rdata = cs ? mem[word_idx] : '0;

endmodule

`default_nettype wire

// File: design/apb_mem.sv
/* Always-ready APB slave. MEMORY_SIZE must be below the bus address
   width; any higher address bit set gives pslverr and no write. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module apb_mem #(
  parameter int MEMORY_SIZE = `APB_MEM_ADDR_BITS
) (
  input logic pclk,
  input logic rst_n,
  apb_if.slave apb
);

  ////////////////////////////////////////
  // Local sizes and signals
  ////////////////////////////////////////

  // log2 of bytes per word
  localparam int DATA_SIZE = $clog2(`APB_DATA_WIDTH / 8);
  localparam int BYTES     = `APB_DATA_WIDTH / 8;

  logic [BYTES-1:0] wr_strb;
  logic             bank_cs;

  ////////////////////////////////////////
  // Response and enables
  ////////////////////////////////////////

  // Out of range when any upper address bit is set
  assign apb.pslverr = |apb.paddr[`APB_ADDR_WIDTH-1:MEMORY_SIZE];

  // No wait states
  assign apb.pready = 1'b1;

  // Reads carry no strobes into the bank
  assign wr_strb = apb.pstrb & {BYTES{apb.pwrite}};

  // Bank active only in access phase of a good transfer
  assign bank_cs = rst_n & apb.psel & apb.penable & ~apb.pslverr;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  mem_bank #(
    .ADDR_WIDTH (MEMORY_SIZE),
    .DATA_SIZE  (DATA_SIZE)
  ) u_mem_bank (
    .pclk  (pclk),
    .cs    (bank_cs),
    .addr  (apb.paddr[MEMORY_SIZE-1:0]),
    .wdata (apb.pwdata),
    .wstrb (wr_strb),
    .rdata (apb.prdata)
  );

endmodule

`default_nettype wire

// File: design/apb_master_ctrl.sv
/* One APB transfer per four-phase req/ack command. ack rises three
   edges after req is sampled and holds until req is seen low. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module apb_master_ctrl (
  input  logic                         pclk,
  input  logic                         rst_n,
  input  logic                         req,
  output logic                         ack,
  input  logic                         cmd_write,
  input  logic [`APB_ADDR_WIDTH-1:0]   cmd_addr,
  input  logic [`APB_DATA_WIDTH-1:0]   cmd_wdata,
  input  logic [`APB_DATA_WIDTH/8-1:0] cmd_strb,
  output logic [`APB_DATA_WIDTH-1:0]   rsp_rdata,
  output logic                         rsp_err,
  apb_if.master apb
);

  ////////////////////////////////////////
  // State and command registers
  ////////////////////////////////////////

  apb_pkg::ctrl_state_e state_q;
  apb_pkg::ctrl_state_e state_d;

  // Command held stable from setup through access
  logic [`APB_ADDR_WIDTH-1:0]   paddr_q;
  logic [`APB_DATA_WIDTH-1:0]   pwdata_q;
  logic [`APB_DATA_WIDTH/8-1:0] pstrb_q;
  apb_pkg::apb_op_e             op_q;

  logic start;

  // New command accepted in IDLE
  assign start = (state_q == apb_pkg::IDLE) && req;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      apb_pkg::IDLE: begin
        if (req) begin
          state_d = apb_pkg::SETUP;
        end
      end
      // Setup always lasts one cycle
      apb_pkg::SETUP: state_d = apb_pkg::ACCESS;
      apb_pkg::ACCESS: begin
        if (apb.pready) begin
          state_d = apb_pkg::DONE;
        end
      end
      // Hold response until host drops req
      apb_pkg::DONE: begin
        if (!req) begin
          state_d = apb_pkg::IDLE;
        end
      end
      default: state_d = apb_pkg::IDLE;
    endcase
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= apb_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Latch command on IDLE to SETUP
  always_ff @(posedge pclk) begin
    if (start) begin
      paddr_q  <= cmd_addr;
      pwdata_q <= cmd_wdata;
      pstrb_q  <= cmd_strb;
      op_q     <= cmd_write ? apb_pkg::OP_WRITE : apb_pkg::OP_READ;
    end
  end

  ////////////////////////////////////////
  // Response capture
  ////////////////////////////////////////

  // Sampled at end of access phase
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_rdata <= '0;
      rsp_err   <= 1'b0;
    end else if ((state_q == apb_pkg::ACCESS) && apb.pready) begin
      rsp_rdata <= apb.prdata;
      rsp_err   <= apb.pslverr;
    end
  end

  // Bus drive decoded from state
  assign apb.psel    = (state_q == apb_pkg::SETUP) || (state_q == apb_pkg::ACCESS);
  assign apb.penable = (state_q == apb_pkg::ACCESS);
  assign apb.paddr   = paddr_q;
  assign apb.pwdata  = pwdata_q;
  assign apb.pstrb   = pstrb_q;
  assign apb.pwrite  = (op_q == apb_pkg::OP_WRITE);

  // Handshake done
  assign ack = (state_q == apb_pkg::DONE);

endmodule

`default_nettype wire

// File: design/apb_mem_sys.sv
/* APB memory subsystem with a four-phase host port.
   One command in flight; 256 bytes implemented, higher addresses error. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module apb_mem_sys (
  input  logic                         pclk,
  input  logic                         rst_n,
  // Host handshake
  input  logic                         req,
  output logic                         ack,
  // Host command
  input  logic                         cmd_write,
  input  logic [`APB_ADDR_WIDTH-1:0]   cmd_addr,
  input  logic [`APB_DATA_WIDTH-1:0]   cmd_wdata,
  input  logic [`APB_DATA_WIDTH/8-1:0] cmd_strb,
  // Host response
  output logic [`APB_DATA_WIDTH-1:0]   rsp_rdata,
  output logic                         rsp_err
);

  ////////////////////////////////////////
  // Internal APB bus
  ////////////////////////////////////////

  apb_if u_apb_bus ();

  // Host side to APB master
  apb_master_ctrl u_ctrl (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_strb  (cmd_strb),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err),
    .apb       (u_apb_bus.master)
  );

  // Memory slave
  apb_mem #(
    .MEMORY_SIZE (`APB_MEM_ADDR_BITS)
  ) u_mem (
    .pclk  (pclk),
    .rst_n (rst_n),
    .apb   (u_apb_bus.slave)
  );

endmodule

`default_nettype wire

// File: tb/apb_mem_sys_sva.sv
/* Handshake, APB and reset checks bound into apb_mem_sys.
   Assumes pready is tied high, so the access phase lasts one cycle. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module apb_mem_sys_sva (
  input logic                         pclk, rst_n, req, ack, rsp_err,
  input logic [`APB_DATA_WIDTH-1:0]   rsp_rdata, pwdata,
  input logic                         psel, penable, pwrite,
  input logic [`APB_ADDR_WIDTH-1:0]   paddr,
  input logic [`APB_DATA_WIDTH/8-1:0] pstrb,
  input apb_pkg::ctrl_state_e         ctrl_state
);

  // Failure count, read back at the end of the run
  int sva_errors = 0;

  ////////////////////////////////////////
  // Host handshake
  ////////////////////////////////////////

  // req seen in IDLE three edges before ack is first sampled high
  a_ack_latency: assert property (@(posedge pclk) disable iff (!rst_n)
      $rose(ack) |-> ($past(ctrl_state, 3) == apb_pkg::IDLE) && $past(req, 3)) else begin
    $error("ack did not rise three cycles after req");
    sva_errors++;
  end

  // ack follows req one edge later once in DONE
  a_ack_follow: assert property (@(posedge pclk) disable iff (!rst_n)
      ack |=> (ack == $past(req))) else begin
    $error("ack did not track req in the response phase");
    sva_errors++;
  end

  // Response held for the whole ack phase
  a_rsp_stable: assert property (@(posedge pclk) disable iff (!rst_n)
      ($past(ack) && ack) |-> $stable(rsp_rdata) && $stable(rsp_err)) else begin
    $error("response changed while ack was high");
    sva_errors++;
  end

  ////////////////////////////////////////
  // APB bus
  ////////////////////////////////////////

  // Access only right after a setup cycle
  a_penable_setup: assert property (@(posedge pclk) disable iff (!rst_n)
      penable |-> $past(psel) && !$past(penable)) else begin
    $error("penable rose without a setup cycle before it");
    sva_errors++;
  end

  a_bus_stable: assert property (@(posedge pclk) disable iff (!rst_n)
      (psel && penable) |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata)
      && $stable(pstrb)) else begin
    $error("APB request changed between setup and access");
    sva_errors++;
  end

  // Quiet bus and host port in reset and the first cycle out of it
  a_reset_quiet: assert property (@(posedge pclk)
      (!rst_n || $rose(rst_n)) |-> !ack && !psel && !penable) else begin
    $error("ack, psel or penable high around reset");
    sva_errors++;
  end

endmodule

bind apb_mem_sys apb_mem_sys_sva u_sva (
  .pclk (pclk), .rst_n (rst_n), .req (req), .ack (ack),
  .rsp_rdata (rsp_rdata), .rsp_err (rsp_err),
  .psel (u_apb_bus.psel), .penable (u_apb_bus.penable), .pwrite (u_apb_bus.pwrite),
  .paddr (u_apb_bus.paddr), .pwdata (u_apb_bus.pwdata), .pstrb (u_apb_bus.pstrb),
  .ctrl_state (u_ctrl.state_q)
);

`default_nettype wire

// File: tb/tb_apb_mem_sys.sv
/* Testbench for the APB memory subsystem. Every word is written before
   any read; handshake and bus timing are checked by the bound SVA module. */

`timescale 1ns/10ps
`default_nettype none

`include "apb_consts.svh"

module tb_apb_mem_sys;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_WORDS    = 64;
  localparam int NUM_READBACK = 8;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_OOR      = 20;
  // Three commands per out-of-range case
  localparam int NUM_CMDS    = NUM_WORDS + NUM_READBACK + NUM_RANDOM + 3 * NUM_OOR;
  localparam int CYCLE_LIMIT = RESET_CYCLES + 40 * NUM_CMDS;

  logic                         pclk, rst_n, req, ack, cmd_write, rsp_err;
  logic [`APB_ADDR_WIDTH-1:0]   cmd_addr;
  logic [`APB_DATA_WIDTH-1:0]   cmd_wdata, rsp_rdata;
  logic [`APB_DATA_WIDTH/8-1:0] cmd_strb;

  // Byte-level model of the 256 implemented bytes
  logic [7:0]  ref_mem [256];
  logic [31:0] lcg_state = 32'd47960;
  int          errors = 0;
  int          cycle_count = 0;

  apb_mem_sys u_dut (
    .pclk (pclk), .rst_n (rst_n), .req (req), .ack (ack),
    .cmd_write (cmd_write), .cmd_addr (cmd_addr), .cmd_wdata (cmd_wdata),
    .cmd_strb (cmd_strb), .rsp_rdata (rsp_rdata), .rsp_err (rsp_err)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // Watchdog on total run length
  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge pclk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  // Upper half of the LCG state since the low bits are weak
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // Little endian so byte lane i holds byte address base+i
  function automatic logic [31:0] ref_word(input logic [7:0] addr);
    logic [31:0] word;
    for (int i = 0; i < 4; i++) begin
      word[8*i +: 8] = ref_mem[{addr[7:2], 2'b00} + 8'(i)];
    end
    return word;
  endfunction

  task automatic ref_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        ref_mem[{addr[7:2], 2'b00} + 8'(i)] = data[8*i +: 8];
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // One four-phase command with the response sampled on the falling edge
  task automatic run_cmd(input apb_pkg::apb_op_e op, input logic [15:0] addr,
                         input logic [31:0] wdata, input logic [3:0] strb,
                         output logic [31:0] rdata, output logic err);
    logic [15:0] hold;
    @(negedge pclk);
    cmd_write = (op == apb_pkg::OP_WRITE);
    cmd_addr  = addr;
    cmd_wdata = wdata;
    cmd_strb  = strb;
    req       = 1'b1;
    while (!ack) @(negedge pclk);
    // Host back-pressure keeps ack and the response up for 0 to 3 more cycles
    hold = lcg_next();
    repeat (hold[1:0]) @(negedge pclk);
    rdata = rsp_rdata;
    err   = rsp_err;
    req   = 1'b0;
    while (ack) @(negedge pclk);
  endtask

  initial begin
    logic [31:0]      data, rdata;
    logic [15:0]      rnd, addr;
    logic [7:0]       hi;
    logic             err;
    apb_pkg::apb_op_e op;
    rst_n = 1'b0;
    req = 1'b0;
    cmd_write = 1'b0;
    cmd_addr = '0;
    cmd_wdata = '0;
    cmd_strb = '0;
    repeat (RESET_CYCLES) @(posedge pclk);
    @(negedge pclk);
    rst_n = 1'b1;

    // Full-word fill of every word and then random readback
    for (int w = 0; w < NUM_WORDS; w++) begin
      addr = 16'(w * 4);
      data = {lcg_next(), lcg_next()};
      run_cmd(apb_pkg::OP_WRITE, addr, data, 4'hF, rdata, err);
      ref_write(addr[7:0], data, 4'hF);
      compare_value("rsp_err", 32'd0, {31'd0, err});
    end
    for (int k = 0; k < NUM_READBACK; k++) begin
      rnd = lcg_next();
      run_cmd(apb_pkg::OP_READ, {8'h00, rnd[7:0]}, 32'd0, 4'h0, rdata, err);
      compare_value("rsp_rdata", ref_word(rnd[7:0]), rdata);
      compare_value("rsp_err", 32'd0, {31'd0, err});
    end

    // Random mix of strobed writes and reads
    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd  = lcg_next();
      addr = {8'h00, rnd[7:0]};
      op   = rnd[12] ? apb_pkg::OP_WRITE : apb_pkg::OP_READ;
      data = {lcg_next(), lcg_next()};
      run_cmd(op, addr, data, rnd[11:8], rdata, err);
      compare_value("rsp_err", 32'd0, {31'd0, err});
      if (op == apb_pkg::OP_WRITE) begin
        ref_write(addr[7:0], data, rnd[11:8]);
      end else begin
        compare_value("rsp_rdata", ref_word(addr[7:0]), rdata);
      end
    end

    // Out of range gives the error flag, a zero read and an untouched aliased word
    for (int n = 0; n < NUM_OOR; n++) begin
      rnd = lcg_next();
      hi  = (rnd[15:8] == 8'h00) ? 8'h80 : rnd[15:8];
      addr = {hi, rnd[7:0]};
      data = {lcg_next(), lcg_next()};
      run_cmd(apb_pkg::OP_WRITE, addr, data, 4'hF, rdata, err);
      compare_value("rsp_err", 32'd1, {31'd0, err});
      run_cmd(apb_pkg::OP_READ, addr, 32'd0, 4'h0, rdata, err);
      compare_value("rsp_err", 32'd1, {31'd0, err});
      compare_value("rsp_rdata", 32'd0, rdata);
      run_cmd(apb_pkg::OP_READ, {8'h00, addr[7:0]}, 32'd0, 4'h0, rdata, err);
      compare_value("rsp_err", 32'd0, {31'd0, err});
      compare_value("rsp_rdata", ref_word(addr[7:0]), rdata);
    end

    repeat (4) @(negedge pclk);
    $display("Data errors: %0d, assertion errors: %0d", errors, u_dut.u_sva.sva_errors);
    if (errors == 0 && u_dut.u_sva.sva_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/apb_pkg.sv
design/apb_if.sv
design/mem_bank.sv
design/apb_mem.sv
design/apb_master_ctrl.sv
design/apb_mem_sys.sv
tb/apb_mem_sys_sva.sv
tb/tb_apb_mem_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
verilator --binary --timing --assert --top-module tb_apb_mem_sys -f tb.f -o tb_sim || exit 1
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
